//--- bench/bus_memory_model.sv
`timescale 1ns/1ps

module bus_memory_model (
	input logic clk_i,
	input logic rst_i,
	input logic retry_en_i,
	input dcache_bus_pkg::beat_req_t bus_req_i,
	output dcache_bus_pkg::beat_resp_t bus_resp_o,
	output int ack_count_o,
	output int retry_count_o
);

	localparam int WORDS = 256;

	typedef enum logic [1:0] {
		MEM_IDLE,
		MEM_COUNT,
		MEM_ANSWERED
	} mem_phase_t;

	logic [127:0] mem [WORDS];
	integer seed;
	int delay_left;
	mem_phase_t phase;
	logic [7:0] idx;

	// Each 32-bit word holds a pattern made from its own byte address
	function automatic logic [127:0] fill_beat(int unsigned index);
		logic [127:0] beat;
		logic [31:0] byte_addr;
		for (int w = 0; w < 4; w++) begin
			byte_addr = (index << 4) + 32'(w * 4);
			beat[w*32 +: 32] = {~byte_addr[15:0], byte_addr[15:0]};
		end
		return beat;
	endfunction

	// ============================================================
	// Slave side, answers one held cycle at a time
	// ============================================================

	initial begin
		seed = 32'hcdd7e766;
		for (int i = 0; i < WORDS; i++)
			mem[i] = fill_beat(i);
		bus_resp_o = '0;
		ack_count_o = 0;
		retry_count_o = 0;
		delay_left = 0;
		phase = MEM_IDLE;
		forever begin
			@(negedge clk_i);
			// Ack and retry are single-cycle pulses
			bus_resp_o.ack = 1'b0;
			bus_resp_o.rty = 1'b0;
			if (rst_i || !bus_req_i.cyc) begin
				phase = MEM_IDLE;
			end else begin
				// A new cycle draws its latency once, 1 to 8 clocks
				if (phase == MEM_IDLE) begin
					delay_left = $random(seed) & 7;
					phase = MEM_COUNT;
				end
				if (phase == MEM_COUNT && delay_left != 0) begin
					delay_left--;
				end else if (phase == MEM_COUNT) begin
					idx = bus_req_i.address[11:4];
					bus_resp_o.tranid = bus_req_i.tranid;
					bus_resp_o.data = '0;
					if (retry_en_i && (($random(seed) & 3) == 0)) begin
						bus_resp_o.rty = 1'b1;
						retry_count_o++;
					end else begin
						bus_resp_o.ack = 1'b1;
						ack_count_o++;
						// Stores merge only the selected byte lanes
						if (bus_req_i.we) begin
							for (int b = 0; b < 16; b++) begin
								if (bus_req_i.sel[b])
									mem[idx][b*8 +: 8] = bus_req_i.data[b*8 +: 8];
							end
						end else begin
							bus_resp_o.data = mem[idx];
						end
					end
					phase = MEM_ANSWERED;
				end
			end
		end
	end

endmodule

//--- bench/tb_dcache_line_ctrl.sv
`timescale 1ns/1ps

module tb_dcache_line_ctrl;

	typedef enum logic [1:0] {
		OP_LOAD,
		OP_UNCACHED,
		OP_STORE
	} op_t;

	// One stimulus row
	// Chain lets the next row go out before this one has been answered
	typedef struct packed {
		op_t op;
		logic [3:0] tid;
		logic [31:0] addr;
		logic [63:0] sel;
		logic [31:0] pat;
		logic [3:0] beats;
		logic chain;
		logic rty;
		logic [3:0] lat;
	} row_t;

	localparam int MAX_ROWS = 16;
	localparam int REF_WORDS = 256;

	logic clk;
	logic rst;
	logic retry_en;
	dcache_line_pkg::line_req_t line_req;
	logic [3:0] slot_busy;
	dcache_bus_pkg::beat_req_t bus_req;
	dcache_bus_pkg::beat_resp_t bus_resp;
	dcache_line_pkg::line_resp_t line_resp;
	int ack_count;
	int retry_count;

	row_t rows [MAX_ROWS];
	int n_rows;
	logic [127:0] ref_mem [REF_WORDS];
	logic [3:0] exp_valid;
	logic [3:0] exp_tid [4];
	logic [31:0] exp_addr [4];
	logic [511:0] exp_data [4];
	dcache_bus_pkg::bus_cmd_t exp_cmd [4];
	int exp_lat [4];
	int issue_cycle [4];
	int outstanding;
	int cycle_no;
	int err_count;
	int check_count;
	logic timed_out;
	int group_beats;
	int group_start;

	dcache_line_ctrl i_dut (
		.clk_i(clk),
		.rst_i(rst),
		.line_req_i(line_req),
		.slot_busy_o(slot_busy),
		.bus_req_o(bus_req),
		.bus_resp_i(bus_resp),
		.line_resp_o(line_resp)
	);

	bus_memory_model i_mem (
		.clk_i(clk),
		.rst_i(rst),
		.retry_en_i(retry_en),
		.bus_req_i(bus_req),
		.bus_resp_o(bus_resp),
		.ack_count_o(ack_count),
		.retry_count_o(retry_count)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// ============================================================
	// Reference model and helpers
	// ============================================================

	// Same address-derived fill that the bus memory starts with
	function automatic logic [127:0] initial_beat(int unsigned index);
		logic [127:0] beat;
		logic [31:0] byte_addr;
		for (int w = 0; w < 4; w++) begin
			byte_addr = (index << 4) + 32'(w * 4);
			beat[w*32 +: 32] = {~byte_addr[15:0], byte_addr[15:0]};
		end
		return beat;
	endfunction

	function automatic logic [511:0] make_line(logic [31:0] pat);
		logic [511:0] line;
		for (int w = 0; w < 16; w++)
			line[w*32 +: 32] = pat ^ {4{8'(w)}};
		return line;
	endfunction

	function automatic logic [511:0] read_ref_line(logic [31:0] addr);
		logic [511:0] line;
		for (int b = 0; b < 4; b++)
			line[b*128 +: 128] = ref_mem[{addr[11:6], 2'(b)}];
		return line;
	endfunction

	task automatic check_value(input string what, input logic [511:0] got,
		input logic [511:0] exp);
		check_count++;
		if (got !== exp) begin
			err_count++;
			$display("** Error at %0d ns: %s, got %0h expected %0h", $time, what, got, exp);
		end
	endtask

	task automatic add_row(input op_t op, input logic [3:0] tid, input logic [31:0] addr,
		input logic [63:0] sel, input logic [31:0] pat, input logic [3:0] beats,
		input logic chain, input logic rty, input logic [3:0] lat);
		rows[n_rows] = '{op, tid, addr, sel, pat, beats, chain, rty, lat};
		n_rows++;
	endtask

	task automatic build_table();
		n_rows = 0;
		add_row(OP_LOAD, 4'h1, 32'h0000_0040, 64'hffff_ffff_ffff_ffff,
			32'h1111_0000, 4'd4, 1'b0, 1'b0, 4'd0);
		add_row(OP_STORE, 4'h2, 32'h0000_0040, 64'h00f0_0000_0000_0f0f,
			32'h2222_0000, 4'd2, 1'b0, 1'b0, 4'd0);
		add_row(OP_LOAD, 4'h3, 32'h0000_0040, 64'h0000_0000_0000_0000,
			32'h3333_0000, 4'd4, 1'b0, 1'b0, 4'd0);
		add_row(OP_UNCACHED, 4'h0, 32'h0000_0080, 64'h0000_ffff_0000_00ff,
			32'h4444_0000, 4'd2, 1'b0, 1'b0, 4'd0);
		// Empty store finishes on its own, no bus cycle at all
		add_row(OP_STORE, 4'h5, 32'h0000_00c0, 64'h0000_0000_0000_0000,
			32'h5555_0000, 4'd0, 1'b0, 1'b0, 4'd3);
		add_row(OP_STORE, 4'h6, 32'h0000_0100, 64'hffff_0000_0ff0_0001,
			32'h6666_0000, 4'd3, 1'b0, 1'b1, 4'd0);
		add_row(OP_LOAD, 4'h7, 32'h0000_0100, 64'h0000_0000_0000_0000,
			32'h7777_0000, 4'd4, 1'b0, 1'b1, 4'd0);
		add_row(OP_UNCACHED, 4'h4, 32'h0000_0140, 64'h0000_0001_8000_0000,
			32'h8888_0000, 4'd2, 1'b0, 1'b1, 4'd0);
		// Four lines in flight at once, one per slot
		add_row(OP_LOAD, 4'h8, 32'h0000_0200, 64'h0000_0000_0000_0000,
			32'h9999_0000, 4'd4, 1'b1, 1'b1, 4'd0);
		add_row(OP_LOAD, 4'h9, 32'h0000_0240, 64'h0000_0000_0000_0000,
			32'haaaa_0000, 4'd4, 1'b1, 1'b1, 4'd0);
		add_row(OP_LOAD, 4'ha, 32'h0000_0280, 64'h0000_0000_0000_0000,
			32'hbbbb_0000, 4'd4, 1'b1, 1'b1, 4'd0);
		add_row(OP_LOAD, 4'hb, 32'h0000_02c0, 64'h0000_0000_0000_0000,
			32'hcccc_0000, 4'd4, 1'b0, 1'b1, 4'd0);
	endtask

	// Advances one clock, checks the bus command of a held cycle and
	// checks a line response if one is showing
	task automatic step_cycle();
		int s;
		int b;
		@(negedge clk);
		cycle_no++;
		if (bus_req.cyc) begin
			b = int'(bus_req.tranid.slot);
			check_value("bus beat for an outstanding slot", exp_valid[b], 1'b1);
			check_value("bus command", bus_req.cmd, exp_cmd[b]);
		end
		if (line_resp.ack) begin
			s = int'(line_resp.tid[1:0]);
			check_value("ack for an outstanding slot", exp_valid[s], 1'b1);
			check_value("ack tid", line_resp.tid, exp_tid[s]);
			check_value("ack line address", line_resp.address, exp_addr[s]);
			check_value("ack line data", line_resp.data, exp_data[s]);
			if (exp_lat[s] != 0)
				check_value("ack latency", cycle_no - issue_cycle[s], exp_lat[s]);
			exp_valid[s] = 1'b0;
			outstanding--;
		end
	endtask

	task automatic issue_row(input row_t r);
		int s;
		int n;
		logic [511:0] req_data;
		logic [511:0] ref_line;
		logic [511:0] exp;
		s = int'(r.tid[1:0]);
		n = 0;
		while (slot_busy[s] && !timed_out) begin
			step_cycle();
			n++;
			if (n > 200) begin
				$display("Timeout: slot %0d stayed busy for 200 cycles", s);
				timed_out = 1'b1;
			end
		end
		if (!timed_out) begin
			req_data = make_line(r.pat);
			ref_line = read_ref_line(r.addr);
			// Loads take memory beats where the bus is used, stores echo their data
			for (int b = 0; b < 4; b++) begin
				if (r.op == OP_LOAD || (r.op == OP_UNCACHED && |r.sel[b*16 +: 16]))
					exp[b*128 +: 128] = ref_line[b*128 +: 128];
				else
					exp[b*128 +: 128] = req_data[b*128 +: 128];
			end
			if (r.op == OP_STORE) begin
				for (int j = 0; j < 64; j++) begin
					if (r.sel[j])
						ref_line[j*8 +: 8] = req_data[j*8 +: 8];
				end
				for (int b = 0; b < 4; b++)
					ref_mem[{r.addr[11:6], 2'(b)}] = ref_line[b*128 +: 128];
			end
			// The retry mode only changes while the bus is quiet
			if (outstanding == 0)
				retry_en = r.rty;
			line_req.cyc = 1'b1;
			line_req.we = (r.op == OP_STORE);
			line_req.cacheable = (r.op == OP_LOAD);
			line_req.tid = r.tid;
			line_req.address = r.addr;
			line_req.sel = r.sel;
			line_req.data = req_data;
			exp_valid[s] = 1'b1;
			exp_tid[s] = r.tid;
			exp_addr[s] = {r.addr[31:6], 6'd0};
			exp_data[s] = exp;
			// Every beat of a line carries the command of its request kind
			if (r.op == OP_STORE)
				exp_cmd[s] = dcache_bus_pkg::STORE;
			else if (r.op == OP_LOAD)
				exp_cmd[s] = dcache_bus_pkg::LOAD_LINE;
			else
				exp_cmd[s] = dcache_bus_pkg::LOAD_UNCACHED;
			exp_lat[s] = int'(r.lat);
			issue_cycle[s] = cycle_no;
			outstanding++;
			step_cycle();
			line_req.cyc = 1'b0;
		end
	endtask

	task automatic wait_idle();
		int n;
		n = 0;
		while (outstanding != 0 && !timed_out) begin
			step_cycle();
			n++;
			if (n > 5000) begin
				$display("Timeout: %0d line responses never arrived", outstanding);
				timed_out = 1'b1;
			end
		end
	endtask

	// ============================================================
	// Main sequence
	// ============================================================

	initial begin
		rst = 1'b1;
		retry_en = 1'b0;
		line_req = '0;
		exp_valid = '0;
		outstanding = 0;
		cycle_no = 0;
		err_count = 0;
		check_count = 0;
		timed_out = 1'b0;
		for (int i = 0; i < REF_WORDS; i++)
			ref_mem[i] = initial_beat(i);
		build_table();
		repeat (16) @(negedge clk);
		rst = 1'b0;
		step_cycle();
		check_value("bus cyc after reset", bus_req.cyc, 1'b0);
		check_value("line ack after reset", line_resp.ack, 1'b0);
		check_value("slot busy after reset", slot_busy, 4'd0);
		group_beats = 0;
		group_start = ack_count;
		for (int r = 0; r < n_rows && !timed_out; r++) begin
			issue_row(rows[r]);
			group_beats += int'(rows[r].beats);
			if (!rows[r].chain && !timed_out) begin
				wait_idle();
				check_value("acknowledged bus beats", ack_count - group_start, group_beats);
				group_beats = 0;
				group_start = ack_count;
			end
		end
		// The retry rows only prove something if the memory did retry
		check_value("bus retries seen", retry_count != 0, 1'b1);
		$display("Checks: %0d, errors: %0d, bus beats: %0d, retries: %0d",
			check_count, err_count, ack_count, retry_count);
		if (err_count == 0 && !timed_out)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

//--- dcache_line_ctrl.f
hw/dcache_bus_pkg.sv
hw/dcache_line_pkg.sv
hw/slot_picker.sv
hw/request_steer.sv
hw/line_slot.sv
hw/bus_issue.sv
hw/line_return.sv
hw/dcache_line_ctrl.sv
bench/bus_memory_model.sv
bench/tb_dcache_line_ctrl.sv

//--- hw/bus_issue.sv
`timescale 1ns/1ps

module bus_issue #(
	parameter int SLOTS = 4,
	parameter int WAIT_CYCLES = 6,
	parameter logic [16:0] LFSR_SEED = 17'h0ace1
) (
	input logic clk_i,
	input logic rst_i,
	input logic [SLOTS-1:0] beat_pend_i,
	input dcache_bus_pkg::beat_req_t beat_req_i [SLOTS],
	output logic [SLOTS-1:0] issue_o,
	output dcache_bus_pkg::beat_req_t bus_req_o,
	input dcache_bus_pkg::beat_resp_t bus_resp_i
);

	localparam int SLOT_BITS = $clog2(SLOTS);
	localparam int CNT_BITS = $clog2(WAIT_CYCLES + 1);

	typedef enum logic [1:0] {
		ISS_IDLE,
		ISS_BUSY,
		ISS_BACKOFF
	} iss_state_t;

	iss_state_t state;
	logic any;
	logic [SLOT_BITS-1:0] pick_idx;
	dcache_bus_pkg::beat_req_t pick_req;
	dcache_bus_pkg::beat_req_t req_q;
	logic cyc_q;
	logic [CNT_BITS-1:0] wait_cnt;
	logic [16:0] lfsr;
	logic wait_over;

	slot_picker #(
		.payload_t(dcache_bus_pkg::beat_req_t),
		.SLOTS(SLOTS)
	) i_pick (
		.req_i(beat_pend_i),
		.payload_i(beat_req_i),
		.any_o(any),
		.index_o(pick_idx),
		.payload_o(pick_req)
	);

	// Picked slot marks its beat as out in the same clock we latch it
	assign issue_o = (state == ISS_IDLE && any) ? (SLOTS'(1) << pick_idx) : '0;

	// ============================================================
	// Random back-off source
	// ============================================================

	// 17-bit maximal length LFSR, taps at 17 and 14
	always_ff @(posedge clk_i, posedge rst_i) begin
		if (rst_i)
			lfsr <= LFSR_SEED;
		else
			lfsr <= {lfsr[15:0], lfsr[16] ^ lfsr[13]};
	end

	// Fixed wait first, then hold until two LFSR bits line up
	assign wait_over = (wait_cnt == CNT_BITS'(WAIT_CYCLES)) && lfsr[2] && lfsr[1];

	// ============================================================
	// Bus master FSM
	// ============================================================

	always_ff @(posedge clk_i, posedge rst_i) begin
		if (rst_i) begin
			state <= ISS_IDLE;
			cyc_q <= 1'b0;
			wait_cnt <= '0;
		end else begin
			case (state)
			ISS_IDLE: begin
				if (any) begin
					cyc_q <= 1'b1;
					state <= ISS_BUSY;
				end
			end
			ISS_BUSY: begin
				// Ack and retry both end the cycle, the slot sorts out which
				if (bus_resp_i.ack || bus_resp_i.rty) begin
					cyc_q <= 1'b0;
					wait_cnt <= '0;
					state <= ISS_BACKOFF;
				end
			end
			ISS_BACKOFF: begin
				if (wait_over)
					state <= ISS_IDLE;
				else if (wait_cnt != CNT_BITS'(WAIT_CYCLES))
					wait_cnt <= wait_cnt + 1'b1;
			end
			default: state <= ISS_IDLE;
			endcase
		end
	end

	// Beat contents stay put for the whole cycle
	always_ff @(posedge clk_i) begin
		if (state == ISS_IDLE && any)
			req_q <= pick_req;
	end

	always_comb begin
		bus_req_o = req_q;
		bus_req_o.cyc = cyc_q;
	end

endmodule

//--- hw/dcache_bus_pkg.sv
package dcache_bus_pkg;

	// ============================================================
	// Beat geometry
	// ============================================================

	// One bus beat carries a quarter of a cache line
	localparam int BEAT_BITS = 128;
	localparam int BEATS_PER_LINE = 4;

	// One byte select per byte lane of a beat
	localparam int SEL_BITS = 16;
	localparam int ADDR_BITS = 32;

	// Byte offset of a beat inside its line starts above these bits
	localparam int BEAT_OFFSET_BITS = $clog2(SEL_BITS);

	// Width of the beat number and of the slot number in a tranid
	localparam int BEAT_ID_BITS = $clog2(BEATS_PER_LINE);
	localparam int SLOT_ID_BITS = 2;

	// ============================================================
	// Bus commands and transaction ids
	// ============================================================

	// Store covers both uncached and write-through writes
	typedef enum logic [1:0] {
		LOAD_LINE = 2'd0,
		LOAD_UNCACHED = 2'd1,
		STORE = 2'd2
	} bus_cmd_t;

	// The slot number sits above the beat number so that a response
	// can be routed straight back to its slot and beat position
	typedef struct packed {
		logic [SLOT_ID_BITS-1:0] slot;
		logic [BEAT_ID_BITS-1:0] beat;
	} tranid_t;

	// A bus master holds cyc high until it sees ack or rty
	typedef struct packed {
		logic cyc;
		logic we;
		bus_cmd_t cmd;
		tranid_t tranid;
		logic [ADDR_BITS-1:0] address;
		logic [SEL_BITS-1:0] sel;
		logic [BEAT_BITS-1:0] data;
	} beat_req_t;

	// Ack and rty are single-cycle pulses from the memory side
	typedef struct packed {
		logic ack;
		logic rty;
		tranid_t tranid;
		logic [BEAT_BITS-1:0] data;
	} beat_resp_t;

endpackage

//--- hw/dcache_line_ctrl.sv
`timescale 1ns/1ps

module dcache_line_ctrl #(
	parameter int SLOTS = 4,
	parameter int WAIT_CYCLES = 6,
	parameter logic [16:0] LFSR_SEED = 17'h0ace1
) (
	input logic clk_i,
	input logic rst_i,
	input dcache_line_pkg::line_req_t line_req_i,
	output logic [SLOTS-1:0] slot_busy_o,
	output dcache_bus_pkg::beat_req_t bus_req_o,
	input dcache_bus_pkg::beat_resp_t bus_resp_i,
	output dcache_line_pkg::line_resp_t line_resp_o
);

	logic [SLOTS-1:0] slot_load;
	dcache_line_pkg::line_req_t slot_req;
	logic [dcache_bus_pkg::BEATS_PER_LINE-1:0] beat_need;
	logic [SLOTS-1:0] beat_pend;
	dcache_bus_pkg::beat_req_t beat_req [SLOTS];
	logic [SLOTS-1:0] issue;
	logic [SLOTS-1:0] line_done;
	dcache_line_pkg::line_resp_t slot_resp [SLOTS];
	logic [SLOTS-1:0] release_slot;

	// ============================================================
	// CPU request intake
	// ============================================================

	request_steer #(.SLOTS(SLOTS)) i_steer (
		.clk_i(clk_i),
		.rst_i(rst_i),
		.line_req_i(line_req_i),
		.slot_busy_i(slot_busy_o),
		.slot_load_o(slot_load),
		.slot_req_o(slot_req),
		.beat_need_o(beat_need)
	);

	// One slot per transaction id, the bus response is seen by all of them
	for (genvar g = 0; g < SLOTS; g++) begin : g_slot
		line_slot #(.SLOT_NO(g)) i_slot (
			.clk_i(clk_i),
			.rst_i(rst_i),
			.load_i(slot_load[g]),
			.req_i(slot_req),
			.need_i(beat_need),
			.issue_i(issue[g]),
			.resp_i(bus_resp_i),
			.release_i(release_slot[g]),
			.busy_o(slot_busy_o[g]),
			.beat_pend_o(beat_pend[g]),
			.beat_req_o(beat_req[g]),
			.line_done_o(line_done[g]),
			.line_resp_o(slot_resp[g])
		);
	end

	// ============================================================
	// Bus side and line return
	// ============================================================

	bus_issue #(
		.SLOTS(SLOTS),
		.WAIT_CYCLES(WAIT_CYCLES),
		.LFSR_SEED(LFSR_SEED)
	) i_issue (
		.clk_i(clk_i),
		.rst_i(rst_i),
		.beat_pend_i(beat_pend),
		.beat_req_i(beat_req),
		.issue_o(issue),
		.bus_req_o(bus_req_o),
		.bus_resp_i(bus_resp_i)
	);

	line_return #(.SLOTS(SLOTS)) i_return (
		.clk_i(clk_i),
		.rst_i(rst_i),
		.line_done_i(line_done),
		.line_resp_i(slot_resp),
		.release_o(release_slot),
		.line_resp_o(line_resp_o)
	);

endmodule

//--- hw/dcache_line_pkg.sv
package dcache_line_pkg;

	// ============================================================
	// Line geometry
	// ============================================================

	// A cache line is four bus beats wide
	localparam int LINE_BITS = 512;

	// One select bit per byte of the line
	localparam int LINE_SEL_BITS = 64;

	// Address bits below the line boundary
	localparam int OFFSET_BITS = 6;

	// CPU transaction id, the low bits choose the slot
	typedef logic [3:0] cpu_tid_t;

	// ============================================================
	// CPU side request and response
	// ============================================================

	// Cyc is a one-cycle strobe from the CPU
	typedef struct packed {
		logic cyc;
		logic we;
		logic cacheable;
		cpu_tid_t tid;
		logic [dcache_bus_pkg::ADDR_BITS-1:0] address;
		logic [LINE_SEL_BITS-1:0] sel;
		logic [LINE_BITS-1:0] data;
	} line_req_t;

	// Ack pulses for one cycle when the whole line is back
	typedef struct packed {
		logic ack;
		cpu_tid_t tid;
		logic [dcache_bus_pkg::ADDR_BITS-1:0] address;
		logic [LINE_BITS-1:0] data;
	} line_resp_t;

endpackage

//--- hw/line_return.sv
`timescale 1ns/1ps

module line_return #(
	parameter int SLOTS = 4
) (
	input logic clk_i,
	input logic rst_i,
	input logic [SLOTS-1:0] line_done_i,
	input dcache_line_pkg::line_resp_t line_resp_i [SLOTS],
	output logic [SLOTS-1:0] release_o,
	output dcache_line_pkg::line_resp_t line_resp_o
);

	localparam int SLOT_BITS = $clog2(SLOTS);

	logic any;
	logic [SLOT_BITS-1:0] pick_idx;
	dcache_line_pkg::line_resp_t pick_resp;
	dcache_line_pkg::line_resp_t resp_q;
	logic ack_q;

	slot_picker #(
		.payload_t(dcache_line_pkg::line_resp_t),
		.SLOTS(SLOTS)
	) i_pick (
		.req_i(line_done_i),
		.payload_i(line_resp_i),
		.any_o(any),
		.index_o(pick_idx),
		.payload_o(pick_resp)
	);

	// Releasing in the pick cycle drops the slot's done level before the
	// next pick, so every line goes out once
	assign release_o = any ? (SLOTS'(1) << pick_idx) : '0;

	always_ff @(posedge clk_i, posedge rst_i) begin
		if (rst_i)
			ack_q <= 1'b0;
		else
			ack_q <= any;
	end

	always_ff @(posedge clk_i) begin
		if (any)
			resp_q <= pick_resp;
	end

	// Ack comes from its own flop, the rest is the captured line
	always_comb begin
		line_resp_o = resp_q;
		line_resp_o.ack = ack_q;
	end

endmodule

//--- hw/line_slot.sv
`timescale 1ns/1ps

module line_slot #(
	parameter int SLOT_NO = 0
) (
	input logic clk_i,
	input logic rst_i,
	input logic load_i,
	input dcache_line_pkg::line_req_t req_i,
	input logic [dcache_bus_pkg::BEATS_PER_LINE-1:0] need_i,
	input logic issue_i,
	input dcache_bus_pkg::beat_resp_t resp_i,
	input logic release_i,
	output logic busy_o,
	output logic beat_pend_o,
	output dcache_bus_pkg::beat_req_t beat_req_o,
	output logic line_done_o,
	output dcache_line_pkg::line_resp_t line_resp_o
);

	localparam int BEATS = dcache_bus_pkg::BEATS_PER_LINE;
	localparam int BEAT_BITS = dcache_bus_pkg::BEAT_BITS;
	localparam int SEL_BITS = dcache_bus_pkg::SEL_BITS;
	localparam int ADDR_BITS = dcache_bus_pkg::ADDR_BITS;
	localparam int BEAT_ID_BITS = dcache_bus_pkg::BEAT_ID_BITS;
	localparam int SLOT_ID_BITS = dcache_bus_pkg::SLOT_ID_BITS;
	localparam int OFFSET_BITS = dcache_line_pkg::OFFSET_BITS;

	logic busy;
	logic [BEATS-1:0] out_q;
	logic [BEATS-1:0] done_q;
	logic [BEATS-1:0] pend_vec;
	logic [BEAT_ID_BITS-1:0] pick;
	logic resp_hit;
	dcache_line_pkg::line_req_t req_q;
	logic [dcache_line_pkg::LINE_BITS-1:0] data_q;

	// ============================================================
	// Beat bookkeeping
	// ============================================================

	// A beat is pending while it is neither on the bus nor finished
	assign pend_vec = {BEATS{busy}} & ~out_q & ~done_q;
	assign beat_pend_o = |pend_vec;

	// Lowest pending beat goes first
	always_comb begin
		pick = '0;
		for (int b = BEATS-1; b >= 0; b--) begin
			if (pend_vec[b])
				pick = BEAT_ID_BITS'(b);
		end
	end

	// Only a beat that is actually out may be answered
	assign resp_hit = busy &&
		resp_i.tranid.slot == SLOT_ID_BITS'(SLOT_NO) &&
		out_q[resp_i.tranid.beat];

	always_ff @(posedge clk_i, posedge rst_i) begin
		if (rst_i) begin
			busy <= 1'b0;
			out_q <= '0;
			done_q <= '0;
		end else begin
			if (load_i) begin
				busy <= 1'b1;
				out_q <= '0;
				// Beats the request does not touch finish without a bus cycle
				done_q <= ~need_i;
			end else begin
				if (release_i)
					busy <= 1'b0;
				if (issue_i)
					out_q[pick] <= 1'b1;
				if (resp_hit && resp_i.ack) begin
					done_q[resp_i.tranid.beat] <= 1'b1;
					out_q[resp_i.tranid.beat] <= 1'b0;
				end else if (resp_hit && resp_i.rty) begin
					// Retried beat drops back to pending and gets re-issued
					out_q[resp_i.tranid.beat] <= 1'b0;
				end
			end
		end
	end

	// ============================================================
	// Request hold and line assembly
	// ============================================================

	// The line starts out as the request data so a store returns what it wrote
	always_ff @(posedge clk_i) begin
		if (load_i) begin
			req_q <= req_i;
			data_q <= req_i.data;
		end else if (resp_hit && resp_i.ack && !req_q.we) begin
			data_q[resp_i.tranid.beat*BEAT_BITS +: BEAT_BITS] <= resp_i.data;
		end
	end

	// Busy shows up as soon as the steer strobes us, so a second request
	// to this slot is refused in the very next cycle
	assign busy_o = busy | load_i;
	assign line_done_o = busy & (&done_q);

	// Bus beat for the lowest pending beat
	always_comb begin
		beat_req_o.cyc = beat_pend_o;
		beat_req_o.we = req_q.we;
		if (req_q.we)
			beat_req_o.cmd = dcache_bus_pkg::STORE;
		else if (req_q.cacheable)
			beat_req_o.cmd = dcache_bus_pkg::LOAD_LINE;
		else
			beat_req_o.cmd = dcache_bus_pkg::LOAD_UNCACHED;
		beat_req_o.tranid.slot = SLOT_ID_BITS'(SLOT_NO);
		beat_req_o.tranid.beat = pick;
		beat_req_o.address = {req_q.address[ADDR_BITS-1:OFFSET_BITS], pick,
			{dcache_bus_pkg::BEAT_OFFSET_BITS{1'b0}}};
		beat_req_o.sel = req_q.sel[pick*SEL_BITS +: SEL_BITS];
		beat_req_o.data = req_q.data[pick*BEAT_BITS +: BEAT_BITS];
	end

	// Line response, the address is rounded down to the line boundary
	always_comb begin
		line_resp_o.ack = line_done_o;
		line_resp_o.tid = req_q.tid;
		line_resp_o.address = {req_q.address[ADDR_BITS-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
		line_resp_o.data = data_q;
	end

endmodule

//--- hw/request_steer.sv
`timescale 1ns/1ps

module request_steer #(
	parameter int SLOTS = 4
) (
	input logic clk_i,
	input logic rst_i,
	input dcache_line_pkg::line_req_t line_req_i,
	input logic [SLOTS-1:0] slot_busy_i,
	output logic [SLOTS-1:0] slot_load_o,
	output dcache_line_pkg::line_req_t slot_req_o,
	output logic [dcache_bus_pkg::BEATS_PER_LINE-1:0] beat_need_o
);

	localparam int SLOT_BITS = $clog2(SLOTS);
	localparam int BEATS = dcache_bus_pkg::BEATS_PER_LINE;
	localparam int SEL_BITS = dcache_bus_pkg::SEL_BITS;

	logic [SLOT_BITS-1:0] slot;
	logic accept;
	logic [BEATS-1:0] need;

	// The low tid bits pick the slot for this line
	assign slot = line_req_i.tid[SLOT_BITS-1:0];

	// A strobe aimed at a busy slot is dropped on the floor
	assign accept = line_req_i.cyc && !slot_busy_i[slot];

	// Cacheable loads fetch the whole line, everything else only touches
	// the beats that have at least one byte select set
	always_comb begin
		for (int b = 0; b < BEATS; b++) begin
			if (line_req_i.cacheable && !line_req_i.we)
				need[b] = 1'b1;
			else
				need[b] = |line_req_i.sel[b*SEL_BITS +: SEL_BITS];
		end
	end

	// Load strobe, one hot on the target slot
	always_ff @(posedge clk_i, posedge rst_i) begin
		if (rst_i) begin
			slot_load_o <= '0;
		end else begin
			if (accept)
				slot_load_o <= SLOTS'(1) << slot;
			else
				slot_load_o <= '0;
		end
	end

	// Request and need mask are captured alongside the strobe
	always_ff @(posedge clk_i) begin
		if (accept) begin
			slot_req_o <= line_req_i;
			beat_need_o <= need;
		end
	end

endmodule

//--- hw/slot_picker.sv
`timescale 1ns/1ps

module slot_picker #(
	parameter type payload_t = logic,
	parameter int SLOTS = 4
) (
	input logic [SLOTS-1:0] req_i,
	input payload_t payload_i [SLOTS],
	output logic any_o,
	output logic [$clog2(SLOTS)-1:0] index_o,
	output payload_t payload_o
);

	localparam int IDX_BITS = $clog2(SLOTS);

	assign any_o = |req_i;

	// Scan from the top down so the lowest requester wins
	always_comb begin
		index_o = '0;
		for (int i = SLOTS-1; i >= 0; i--) begin
			if (req_i[i])
				index_o = IDX_BITS'(i);
		end
	end

	// Payload follows the winning index
	// With no requester this is slot zero and callers ignore it
	assign payload_o = payload_i[index_o];

endmodule

//--- run_sim.sh
#!/bin/sh
# Compile with Verilator, run the testbench, then scan the log for failure
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_dcache_line_ctrl \
	-f dcache_line_ctrl.f -o tb_sim > build.log 2>&1 \
	|| { cat build.log; echo "Verilator build failed"; exit 1; }

./obj_dir/tb_sim > sim.log 2>&1 \
	|| { cat sim.log; echo "Simulation exited with an error"; exit 1; }

cat sim.log
grep -q "SOME TESTS FAILED" sim.log && exit 1 || exit 0
